// File: wormhole_router.f
verilog/wormhole_pkg.sv
verilog/flit_fifo.sv
verilog/route_decode.sv
verilog/rr_arbiter.sv
verilog/route_control.sv
verilog/crossbar.sv
verilog/wormhole_router.sv
tb/tb_wormhole_router.sv

// File: Bender.yml
package:
  name: wormhole_router

sources:
  - verilog/wormhole_pkg.sv
  - verilog/flit_fifo.sv
  - verilog/route_decode.sv
  - verilog/rr_arbiter.sv
  - verilog/route_control.sv
  - verilog/crossbar.sv
  - verilog/wormhole_router.sv
  - target: test
    files:
      - tb/tb_wormhole_router.sv

// File: tb/tb_wormhole_router.sv
// Default router parameters at node (2,2); table packets on W/E/N/S never turn back to their own port
`timescale 1ns/1ps
`default_nettype none

module tb_wormhole_router;

  import wormhole_pkg::*;

  localparam int FLIT_W   = 32;
  localparam int MY_X     = 2;
  localparam int MY_Y     = 2;
  localparam int NUM_ROWS = 14;

  typedef logic [FLIT_W-1:0] flit_t;

  typedef struct
  {
    dir_e src;
    int   dx;
    int   dy;
    int   len;
    int   base;
  } pkt_row_t;

  logic                               clk_i;
  logic                               reset_i;
  logic [NUM_DIRS-1:0]                link_v_i;
  logic [NUM_DIRS-1:0][FLIT_W-1:0]    link_data_i;
  logic [NUM_DIRS-1:0]                link_ready_o;
  logic [NUM_DIRS-1:0]                link_v_o;
  logic [NUM_DIRS-1:0][FLIT_W-1:0]    link_data_o;
  logic [NUM_DIRS-1:0]                link_ready_i;
  logic [2:0]                         my_x_i;
  logic [2:0]                         my_y_i;

  pkt_row_t rows [NUM_ROWS];
  flit_t    send_q [NUM_DIRS][$];
  // Expected flits indexed by output, then by source port
  flit_t    exp_q [NUM_DIRS][NUM_DIRS][$];
  // Expected output of each packet, in order per source port
  dir_e     route_q [NUM_DIRS][$];
  logic [NUM_DIRS-1:0] in_pkt;
  int       cur_src [NUM_DIRS];
  int       remain [NUM_DIRS];
  int       cycle_count = 0;
  int       cycle_limit = 0;

  wormhole_router UUT
    (.clk_i       (clk_i)
    ,.reset_i     (reset_i)
    ,.link_v_i    (link_v_i)
    ,.link_data_i (link_data_i)
    ,.link_ready_o(link_ready_o)
    ,.link_v_o    (link_v_o)
    ,.link_data_o (link_data_o)
    ,.link_ready_i(link_ready_i)
    ,.my_x_i      (my_x_i)
    ,.my_y_i      (my_y_i)
    );

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic stop_with_failure();
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_flit(input string name, input flit_t expected, input flit_t actual);
    if (expected !== actual)
    begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_port(input string name, input dir_e expected, input dir_e actual);
    if (expected !== actual)
    begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_bits(input string name, input logic [NUM_DIRS-1:0] expected,
                            input logic [NUM_DIRS-1:0] actual);
    if (expected !== actual)
    begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  // XY order: x first, then y, local port when both match
  function automatic dir_e xy_route(input int dx, input int dy);
    if (dx < MY_X)
      return W;
    else if (dx > MY_X)
      return E;
    else if (dy < MY_Y)
      return N;
    else if (dy > MY_Y)
      return S;
    return P;
  endfunction

  // Header is {x, y, len, src, pass, base}; body flits carry src, pass, index and base + index
  function automatic flit_t make_flit(input int r, input int k, input int pass);
    flit_t f;
    if (k == 0)
      f = {3'(rows[r].dx), 3'(rows[r].dy), 4'(rows[r].len), 3'(rows[r].src), 3'(pass),
           16'(rows[r].base)};
    else
      f = {3'(rows[r].src), 3'(pass), 10'(k), 16'(rows[r].base + k)};
    return f;
  endfunction

  task automatic load_table();
    // Local port covers every route, loopback included, back to back
    rows[0]  = '{P, 1, 2, 2, 'h0100};
    rows[1]  = '{P, 3, 2, 1, 'h0200};
    rows[2]  = '{P, 2, 1, 3, 'h0300};
    rows[3]  = '{P, 2, 3, 0, 'h0400};
    rows[4]  = '{P, 2, 2, 2, 'h0500};
    // W and N both head east
    rows[5]  = '{W, 3, 1, 3, 'h0600};
    rows[6]  = '{N, 4, 4, 3, 'h0700};
    // S and E both head west
    rows[7]  = '{S, 0, 0, 2, 'h0800};
    rows[8]  = '{E, 1, 5, 4, 'h0900};
    // W and N both head south
    rows[9]  = '{W, 2, 4, 1, 'h0A00};
    rows[10] = '{N, 2, 3, 2, 'h0B00};
    rows[11] = '{E, 2, 2, 1, 'h0C00};
    rows[12] = '{S, 2, 0, 2, 'h0D00};
    // Longest packet the length field allows
    rows[13] = '{W, 5, 2, 15, 'h0E00};
  endtask

  task automatic queue_pass(input int pass);
    flit_t f;
    dir_e  route;
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      route = xy_route(rows[r].dx, rows[r].dy);
      route_q[rows[r].src].push_back(route);
      for (int k = 0; k <= rows[r].len; k++)
      begin
        f = make_flit(r, k, pass);
        send_q[rows[r].src].push_back(f);
        exp_q[route][rows[r].src].push_back(f);
      end
    end
  endtask

  function automatic bit traffic_pending();
    bit busy;
    busy = 1'b0;
    for (int a = 0; a < NUM_DIRS; a++)
    begin
      if (send_q[a].size() != 0)
        busy = 1'b1;
      for (int b = 0; b < NUM_DIRS; b++)
        if (exp_q[a][b].size() != 0)
          busy = 1'b1;
    end
    return busy;
  endfunction

  // Called at posedge + 1 ns; transfers are sampled at the falling edge before the next posedge
  task automatic run_pass(input bit random_ready);
    while (traffic_pending())
    begin
      for (int s = 0; s < NUM_DIRS; s++)
      begin
        if (send_q[s].size() != 0)
        begin
          link_v_i[s]    = 1'b1;
          link_data_i[s] = send_q[s][0];
        end
        else
        begin
          link_v_i[s]    = 1'b0;
          link_data_i[s] = '0;
        end
        link_ready_i[s] = random_ready ? (($urandom % 4) != 0) : 1'b1;
      end
      @(negedge clk_i);
      for (int s = 0; s < NUM_DIRS; s++)
        if (link_v_i[s] && link_ready_o[s])
          void'(send_q[s].pop_front());
      @(posedge clk_i);
      #1;
    end
    link_v_i     = '0;
    link_data_i  = '0;
    link_ready_i = '1;
  endtask

  // Header picks the source queue; body flits must follow from that same source
  task automatic take_flit(input int o, input flit_t data);
    int src;
    if (!in_pkt[o])
    begin
      src = int'(data[21:19]);
      if (src >= NUM_DIRS || route_q[src].size() == 0)
      begin
        $display("Unexpected header %h leaving output %0d", data, o);
        stop_with_failure();
      end
      check_port($sformatf("link_v_o[%0d] route", o), route_q[src][0], dir_e'(o));
      void'(route_q[src].pop_front());
      cur_src[o] = src;
      remain[o]  = int'(data[25:22]);
      in_pkt[o]  = (remain[o] != 0);
    end
    else
    begin
      src        = cur_src[o];
      remain[o]  = remain[o] - 1;
      in_pkt[o]  = (remain[o] != 0);
    end
    if (src >= NUM_DIRS || exp_q[o][src].size() == 0)
    begin
      $display("Unexpected flit %h leaving output %0d", data, o);
      stop_with_failure();
    end
    check_flit($sformatf("link_data_o[%0d]", o), exp_q[o][src][0], data);
    void'(exp_q[o][src].pop_front());
  endtask

  always @(negedge clk_i)
  begin
    if (reset_i)
    begin
      in_pkt = '0;
      for (int o = 0; o < NUM_DIRS; o++)
      begin
        cur_src[o] = 0;
        remain[o]  = 0;
      end
    end
    else
    begin
      for (int o = 0; o < NUM_DIRS; o++)
        if (link_v_o[o] && link_ready_i[o])
          take_flit(o, link_data_o[o]);
    end
  end

  always @(posedge clk_i)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit)
    begin
      $display("Timeout after %0d cycles with traffic still pending", cycle_limit);
      stop_with_failure();
    end
  end

  initial
  begin
    int total;
    void'($urandom(95089));
    reset_i      = 1'b1;
    link_v_i     = '0;
    link_data_i  = '0;
    link_ready_i = '1;
    my_x_i       = 3'(MY_X);
    my_y_i       = 3'(MY_Y);
    load_table();
    total = 0;
    for (int r = 0; r < NUM_ROWS; r++)
      total = total + rows[r].len + 1;
    // Two passes over the table
    cycle_limit = 200 + 20 * 2 * total;
    repeat (10) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_bits("link_v_o", '0, link_v_o);
    check_bits("link_ready_o", '1, link_ready_o);
    // Full rate first, then random back-pressure on every output
    queue_pass(0);
    run_pass(1'b0);
    queue_pass(1);
    run_pass(1'b1);
    // Idle cycles catch any extra flit leaving after the last expected one
    repeat (10) @(posedge clk_i);
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/wormhole_router.sv
// flit_width_p must exceed x, y and length widths together; W/E/N/S traffic must not turn back
`timescale 1ns/1ps
`default_nettype none

module wormhole_router
  #(parameter int flit_width_p = 32
  ,parameter int  x_width_p    = 3
  ,parameter int  y_width_p    = 3
  ,parameter int  len_width_p  = 4
  ,parameter bit  yx_routing_p = 1'b0)
  (input  logic                                                clk_i
  ,input  logic                                                reset_i
  ,input  logic [wormhole_pkg::NUM_DIRS-1:0]                   link_v_i
  ,input  logic [wormhole_pkg::NUM_DIRS-1:0][flit_width_p-1:0] link_data_i
  ,output logic [wormhole_pkg::NUM_DIRS-1:0]                   link_ready_o
  ,output logic [wormhole_pkg::NUM_DIRS-1:0]                   link_v_o
  ,output logic [wormhole_pkg::NUM_DIRS-1:0][flit_width_p-1:0] link_data_o
  ,input  logic [wormhole_pkg::NUM_DIRS-1:0]                   link_ready_i
  ,input  logic [x_width_p-1:0]                                my_x_i
  ,input  logic [y_width_p-1:0]                                my_y_i
  );

  import wormhole_pkg::*;

  logic [NUM_DIRS-1:0]                   head_v;
  logic [NUM_DIRS-1:0][flit_width_p-1:0] head_data;
  logic [NUM_DIRS-1:0]                   deq;
  dir_mask_t [NUM_DIRS-1:0]              dest;
  dir_mask_t [NUM_DIRS-1:0]              sel;

  // One buffer and one route decoder per input port
  for (genvar i = 0; i < NUM_DIRS; i++)
  begin : g_in
    flit_fifo #(.flit_width_p(flit_width_p)) fifo
      (.clk_i      (clk_i)
      ,.reset_i    (reset_i)
      ,.v_i        (link_v_i[i])
      ,.data_i     (link_data_i[i])
      ,.ready_o    (link_ready_o[i])
      ,.head_v_o   (head_v[i])
      ,.head_data_o(head_data[i])
      ,.yumi_i     (deq[i])
      );

    route_decode
      #(.flit_width_p(flit_width_p)
      ,.x_width_p    (x_width_p)
      ,.y_width_p    (y_width_p)
      ,.len_width_p  (len_width_p)
      ,.yx_routing_p (yx_routing_p))
    decode
      (.clk_i      (clk_i)
      ,.reset_i    (reset_i)
      ,.head_v_i   (head_v[i])
      ,.head_data_i(head_data[i])
      ,.deq_i      (deq[i])
      ,.my_x_i     (my_x_i)
      ,.my_y_i     (my_y_i)
      ,.dest_o     (dest[i])
      );
  end

  route_control
    #(.flit_width_p(flit_width_p)
    ,.x_width_p    (x_width_p)
    ,.y_width_p    (y_width_p)
    ,.len_width_p  (len_width_p))
  control
    (.clk_i       (clk_i)
    ,.reset_i     (reset_i)
    ,.head_v_i    (head_v)
    ,.dest_i      (dest)
    ,.out_data_i  (link_data_o)
    ,.link_ready_i(link_ready_i)
    ,.deq_o       (deq)
    ,.sel_o       (sel)
    ,.link_v_o    (link_v_o)
    );

  // Output data also feeds back to the control for body counting
  crossbar #(.flit_width_p(flit_width_p)) xbar
    (.head_data_i(head_data)
    ,.sel_i      (sel)
    ,.data_o     (link_data_o)
    );

endmodule

`default_nettype wire

// File: verilog/crossbar.sv
// Pure AND-OR switch; each sel_i entry must be one-hot or empty, else the heads are ORed together
`timescale 1ns/1ps
`default_nettype none

module crossbar
  #(parameter int flit_width_p = 32)
  (input  logic [wormhole_pkg::NUM_DIRS-1:0][flit_width_p-1:0] head_data_i
  ,input  wormhole_pkg::dir_mask_t [wormhole_pkg::NUM_DIRS-1:0] sel_i
  ,output logic [wormhole_pkg::NUM_DIRS-1:0][flit_width_p-1:0] data_o
  );

  import wormhole_pkg::*;

  // Idle outputs read as zero
  always_comb
  begin
    for (int o = 0; o < NUM_DIRS; o++)
    begin
      data_o[o] = '0;
      for (int i = 0; i < NUM_DIRS; i++)
        data_o[o] = data_o[o] | (head_data_i[i] & {flit_width_p{sel_i[o][i]}});
    end
  end

endmodule

`default_nettype wire

// File: verilog/route_control.sv
// Output locks are held from a granted header to the last body flit, and across any stall on link_ready_i
`timescale 1ns/1ps
`default_nettype none

module route_control
  #(parameter int flit_width_p = 32
  ,parameter int  x_width_p    = 3
  ,parameter int  y_width_p    = 3
  ,parameter int  len_width_p  = 4)
  (input  logic                                                clk_i
  ,input  logic                                                reset_i
  ,input  logic [wormhole_pkg::NUM_DIRS-1:0]                   head_v_i
  ,input  wormhole_pkg::dir_mask_t [wormhole_pkg::NUM_DIRS-1:0] dest_i
  ,input  logic [wormhole_pkg::NUM_DIRS-1:0][flit_width_p-1:0] out_data_i
  ,input  logic [wormhole_pkg::NUM_DIRS-1:0]                   link_ready_i
  ,output logic [wormhole_pkg::NUM_DIRS-1:0]                   deq_o
  ,output wormhole_pkg::dir_mask_t [wormhole_pkg::NUM_DIRS-1:0] sel_o
  ,output logic [wormhole_pkg::NUM_DIRS-1:0]                   link_v_o
  );

  import wormhole_pkg::*;

  localparam int len_offset_lp = flit_width_p - x_width_p - y_width_p - len_width_p;

  dir_mask_t [NUM_DIRS-1:0]                  req;
  dir_mask_t [NUM_DIRS-1:0]                  arb_req;
  dir_mask_t [NUM_DIRS-1:0]                  grant;
  dir_mask_t [NUM_DIRS-1:0]                  held_r;
  logic [NUM_DIRS-1:0][len_width_p-1:0]      count_r;
  logic [NUM_DIRS-1:0]                       stall_r;
  logic [NUM_DIRS-1:0]                       locked;
  logic [NUM_DIRS-1:0]                       xfer;

  // Requests seen by output o, one bit per input
  always_comb
  begin
    for (int o = 0; o < NUM_DIRS; o++)
    begin
      for (int i = 0; i < NUM_DIRS; i++)
        req[o][i] = head_v_i[i] & dest_i[i][o];
    end
  end

  for (genvar o = 0; o < NUM_DIRS; o++)
  begin : g_out
    // Mid-packet or stalled outputs only listen to their owner
    assign locked[o]   = (count_r[o] != '0) | stall_r[o];
    assign arb_req[o]  = locked[o] ? (req[o] & held_r[o]) : req[o];
    assign link_v_o[o] = |grant[o];
    assign sel_o[o]    = grant[o];
    assign xfer[o]     = link_v_o[o] & link_ready_i[o];

    always_ff @(posedge clk_i)
    begin
      if (reset_i)
      begin
        count_r[o] <= '0;
        stall_r[o] <= 1'b0;
        held_r[o]  <= '0;
      end
      else
      begin
        stall_r[o] <= link_v_o[o] & ~link_ready_i[o];
        if (link_v_o[o] & (count_r[o] == '0))
          held_r[o] <= grant[o];
        if (xfer[o])
        begin
          // Header leaving loads the body count of its packet
          if (count_r[o] == '0)
            count_r[o] <= out_data_i[o][len_offset_lp +: len_width_p];
          else
            count_r[o] <= count_r[o] - 1'b1;
        end
      end
    end

    if (o == P)
    begin : g_local
      // Local port allows loopback, so all five inputs compete
      rr_arbiter #(.inputs_p(NUM_DIRS)) arb
        (.clk_i    (clk_i)
        ,.reset_i  (reset_i)
        ,.reqs_i   (arb_req[o])
        ,.grants_o (grant[o])
        ,.advance_i(xfer[o])
        );
    end
    else
    begin : g_link
      logic [NUM_DIRS-2:0] sub_req;
      logic [NUM_DIRS-2:0] sub_grant;

      // Skip the output's own port when packing the request vector
      always_comb
      begin
        grant[o] = '0;
        for (int j = 0; j < NUM_DIRS-1; j++)
        begin
          sub_req[j] = arb_req[o][(j < o) ? j : j + 1];
          grant[o][(j < o) ? j : j + 1] = sub_grant[j];
        end
      end

      rr_arbiter #(.inputs_p(NUM_DIRS-1)) arb
        (.clk_i    (clk_i)
        ,.reset_i  (reset_i)
        ,.reqs_i   (sub_req)
        ,.grants_o (sub_grant)
        ,.advance_i(xfer[o])
        );
    end
  end

  // An input pops when the output that granted it accepts the flit
  always_comb
  begin
    deq_o = '0;
    for (int o = 0; o < NUM_DIRS; o++)
      deq_o = deq_o | (grant[o] & {NUM_DIRS{link_ready_i[o]}});
  end

endmodule

`default_nettype wire

// File: verilog/rr_arbiter.sv
// Round-robin arbiter; the grant is combinational and the priority only moves when advance_i is high
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter
  #(parameter int inputs_p = 5)
  (input  logic                clk_i
  ,input  logic                reset_i
  ,input  logic [inputs_p-1:0] reqs_i
  ,output logic [inputs_p-1:0] grants_o
  ,input  logic                advance_i
  );

  localparam int ptr_width_lp = $clog2(inputs_p);

  logic [ptr_width_lp-1:0] last_r;
  logic [ptr_width_lp-1:0] winner;
  logic                    found;
  int                      idx;

  // Search starts just past the last winner and wraps around
  always_comb
  begin
    grants_o = '0;
    winner   = last_r;
    found    = 1'b0;
    idx      = 0;
    for (int k = 1; k <= inputs_p; k++)
    begin
      idx = int'(last_r) + k;
      if (idx >= inputs_p)
        idx = idx - inputs_p;
      if (!found && reqs_i[idx])
      begin
        found         = 1'b1;
        winner        = ptr_width_lp'(idx);
        grants_o[idx] = 1'b1;
      end
    end
  end

  // Out of reset input 0 has the highest priority
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      last_r <= ptr_width_lp'(inputs_p - 1);
    else if (advance_i & found)
      last_r <= winner;
  end

endmodule

`default_nettype wire

// File: verilog/route_decode.sv
// Header is {dest x, dest y, length, payload} from the MSB; W/E/N/S traffic must not turn back
`timescale 1ns/1ps
`default_nettype none

module route_decode
  #(parameter int flit_width_p = 32
  ,parameter int  x_width_p    = 3
  ,parameter int  y_width_p    = 3
  ,parameter int  len_width_p  = 4
  ,parameter bit  yx_routing_p = 1'b0)
  (input  logic                    clk_i
  ,input  logic                    reset_i
  ,input  logic                    head_v_i
  ,input  logic [flit_width_p-1:0] head_data_i
  ,input  logic                    deq_i
  ,input  logic [x_width_p-1:0]    my_x_i
  ,input  logic [y_width_p-1:0]    my_y_i
  ,output wormhole_pkg::dir_mask_t dest_o
  );

  import wormhole_pkg::*;

  localparam int x_offset_lp   = flit_width_p - x_width_p;
  localparam int y_offset_lp   = x_offset_lp - y_width_p;
  localparam int len_offset_lp = y_offset_lp - len_width_p;

  logic [x_width_p-1:0]   dest_x;
  logic [y_width_p-1:0]   dest_y;
  logic [len_width_p-1:0] count_r;
  logic                   is_header;
  dir_mask_t              route_n;
  dir_mask_t              dest_r;

  assign dest_x    = head_data_i[x_offset_lp +: x_width_p];
  assign dest_y    = head_data_i[y_offset_lp +: y_width_p];
  // Zero remaining body flits means the head of the buffer is a header
  assign is_header = (count_r == '0);

  // Dimension-ordered route of the current header
  always_comb
  begin
    route_n = '0;
    if (!yx_routing_p)
    begin
      if (dest_x < my_x_i)
        route_n[W] = 1'b1;
      else if (dest_x > my_x_i)
        route_n[E] = 1'b1;
      else if (dest_y < my_y_i)
        route_n[N] = 1'b1;
      else if (dest_y > my_y_i)
        route_n[S] = 1'b1;
      else
        route_n[P] = 1'b1;
    end
    else
    begin
      if (dest_y < my_y_i)
        route_n[N] = 1'b1;
      else if (dest_y > my_y_i)
        route_n[S] = 1'b1;
      else if (dest_x < my_x_i)
        route_n[W] = 1'b1;
      else if (dest_x > my_x_i)
        route_n[E] = 1'b1;
      else
        route_n[P] = 1'b1;
    end
  end

  // Body flits reuse the port chosen by their header
  assign dest_o = head_v_i ? (is_header ? route_n : dest_r) : '0;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      count_r <= '0;
      dest_r  <= '0;
    end
    else if (deq_i & head_v_i)
    begin
      if (is_header)
      begin
        count_r <= head_data_i[len_offset_lp +: len_width_p];
        dest_r  <= route_n;
      end
      else
        count_r <= count_r - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/flit_fifo.sv
// Two-entry buffer; yumi_i must only be raised while head_v_o is high
`timescale 1ns/1ps
`default_nettype none

module flit_fifo
  #(parameter int flit_width_p = 32)
  (input  logic                    clk_i
  ,input  logic                    reset_i
  ,input  logic                    v_i
  ,input  logic [flit_width_p-1:0] data_i
  ,output logic                    ready_o
  ,output logic                    head_v_o
  ,output logic [flit_width_p-1:0] head_data_o
  ,input  logic                    yumi_i
  );

  logic [flit_width_p-1:0] mem_r [0:1];
  logic                    wr_ptr_r;
  logic                    rd_ptr_r;
  logic                    full_r;
  logic                    empty;
  logic                    enq;
  logic                    deq;

  // Equal pointers mean empty unless the full flag says otherwise
  assign empty       = (wr_ptr_r == rd_ptr_r) & ~full_r;
  assign ready_o     = ~full_r;
  assign head_v_o    = ~empty;
  assign head_data_o = mem_r[rd_ptr_r];

  assign enq = v_i & ~full_r;
  assign deq = yumi_i & ~empty;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      full_r   <= 1'b0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= ~wr_ptr_r;
      if (deq)
        rd_ptr_r <= ~rd_ptr_r;
      // A write alone fills the buffer when it holds one flit already
      if (enq & ~deq)
        full_r <= (wr_ptr_r != rd_ptr_r);
      else if (deq & ~enq)
        full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wr_ptr_r] <= data_i;
  end

endmodule

`default_nettype wire

// File: verilog/wormhole_pkg.sv
// Port indices follow P=0, W=1, E=2, N=3, S=4; x grows toward E and y grows toward S
`default_nettype none

package wormhole_pkg;

  // Router port index
  // West and east move along x, north and south along y
  typedef enum logic [2:0]
  {
    P = 3'd0,
    W = 3'd1,
    E = 3'd2,
    N = 3'd3,
    S = 3'd4
  } dir_e;

  // Number of router ports, local port included
  localparam int NUM_DIRS = 5;

  // Set of ports indexed by dir_e
  // Holds at most one bit for a routed flit, none when idle
  typedef logic [NUM_DIRS-1:0] dir_mask_t;

endpackage

`default_nettype wire
